// File: hw/cmd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command processor shared definitions
// Stream word type, command code constants and the state encodings of
// the dispatcher and the loopback response machine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cmd_pkg;

	// One word of the command and response streams
	typedef logic [31:0] word_t;

	// Command code that selects the loopback command
	localparam word_t CC_LOOPBACK = 32'h0000_0001;

	// Filler word that closes a response cut short by a receive stall
	localparam word_t PAD_WORD = 32'hA5A5_0000;

	// Loopback response machine
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		ECHO_CSN  = 3'd1,
		ECHO_CC   = 3'd2,
		ECHO_DATA = 3'd3,
		ECHO_PAD  = 3'd4,
		DONE      = 3'd5
	} loop_state_t;

	// Packet level dispatcher
	typedef enum logic [1:0] {
		GET_CSN = 2'd0,
		GET_CC  = 2'd1,
		RUN     = 2'd2,
		DRAIN   = 2'd3
	} disp_state_t;

endpackage

// File: hw/cmd_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command dispatcher
// Takes the serial number and code words of each packet, starts the
// loopback machine for the loopback code and drains everything else
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module cmd_dispatch (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           rx_valid,
	input  cmd_pkg::word_t rx_data,
	input  logic           rx_last,
	output logic           rx_ready,
	input  logic           sm_rx_ready,
	input  logic           sm_done,
	input  logic           timeout,
	output logic           run_sm,
	output logic           load_csn,
	output logic           load_cc
);

	cmd_pkg::disp_state_t state;
	cmd_pkg::disp_state_t state_next;
	// Word accepted from the receive stream this cycle
	logic rx_xfer;
	// Stall timeout seen while the loopback machine ran
	logic abort_q;

	// Receive ready ownership
	// Header and drain states take every word, RUN hands over to the echo
	always_comb begin
		case (state)
			cmd_pkg::GET_CSN: rx_ready = 1'b1;
			cmd_pkg::GET_CC:  rx_ready = 1'b1;
			cmd_pkg::RUN:     rx_ready = sm_rx_ready;
			cmd_pkg::DRAIN:   rx_ready = 1'b1;
			default:          rx_ready = 1'b0;
		endcase
	end

	assign rx_xfer = rx_valid && rx_ready;

	// Header capture strobes, one cycle each, on the word's own transfer
	assign load_csn = (state == cmd_pkg::GET_CSN) && rx_xfer;
	assign load_cc  = (state == cmd_pkg::GET_CC) && rx_xfer;

	// Loopback machine runs for the whole RUN state
	assign run_sm = (state == cmd_pkg::RUN);

	always_comb begin
		state_next = state;
		case (state)
			cmd_pkg::GET_CSN: begin
				// A serial word marked last is a broken packet, stay put
				if (rx_xfer && !rx_last)
					state_next = cmd_pkg::GET_CC;
			end
			cmd_pkg::GET_CC: begin
				if (rx_xfer) begin
					// Packet ended at the code word, nothing left to echo
					if (rx_last)
						state_next = cmd_pkg::GET_CSN;
					else if (rx_data == cmd_pkg::CC_LOOPBACK)
						state_next = cmd_pkg::RUN;
					else
						state_next = cmd_pkg::DRAIN;
				end
			end
			cmd_pkg::RUN: begin
				// Aborted echo leaves the tail of the packet behind
				if (sm_done)
					state_next = abort_q ? cmd_pkg::DRAIN : cmd_pkg::GET_CSN;
			end
			cmd_pkg::DRAIN: begin
				if (rx_xfer && rx_last)
					state_next = cmd_pkg::GET_CSN;
			end
			default: state_next = cmd_pkg::GET_CSN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= cmd_pkg::GET_CSN;
		else
			state <= state_next;
	end

	// Timeout memory
	// Cleared whenever the loopback machine is not running
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			abort_q <= 1'b0;
		else if (!run_sm)
			abort_q <= 1'b0;
		else if (timeout)
			abort_q <= 1'b1;
	end

endmodule

// File: hw/cc_loopback_sm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loopback command response machine
// Sends the serial number and code back, then echoes the received words
// up to the last one, or closes early with a pad word on a stall timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module cc_loopback_sm (
	input  logic clk,
	input  logic rst_n,
	input  logic run_sm,
	input  logic rx_valid,
	input  logic rx_last,
	output logic sm_rx_ready,
	input  logic tx_ready,
	output logic tx_valid,
	output logic tx_last,
	input  logic timeout,
	output logic echo_wait,
	output logic sm_done,
	output logic send_csn,
	output logic send_cmd,
	output logic send_rx_data,
	output logic send_pad
);

	cmd_pkg::loop_state_t state;
	cmd_pkg::loop_state_t state_next;
	// Echo word moves from receive to transmit this cycle
	logic echo_xfer;

	assign echo_xfer = rx_valid && tx_ready;

	always_comb begin
		state_next = state;
		case (state)
			// Dispatcher only enables us with a header already latched
			cmd_pkg::IDLE: state_next = cmd_pkg::ECHO_CSN;
			cmd_pkg::ECHO_CSN: begin
				if (tx_ready)
					state_next = cmd_pkg::ECHO_CC;
			end
			cmd_pkg::ECHO_CC: begin
				if (tx_ready)
					state_next = cmd_pkg::ECHO_DATA;
			end
			cmd_pkg::ECHO_DATA: begin
				// Completed response wins over a stall abort
				if (echo_xfer && rx_last)
					state_next = cmd_pkg::DONE;
				else if (timeout)
					state_next = cmd_pkg::ECHO_PAD;
			end
			cmd_pkg::ECHO_PAD: begin
				if (tx_ready)
					state_next = cmd_pkg::DONE;
			end
			// Single cycle handshake back to the dispatcher
			cmd_pkg::DONE: state_next = cmd_pkg::IDLE;
			default:       state_next = cmd_pkg::IDLE;
		endcase
	end

	// Held in IDLE whenever the dispatcher drops run_sm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= cmd_pkg::IDLE;
		else if (!run_sm)
			state <= cmd_pkg::IDLE;
		else
			state <= state_next;
	end

	// Transmit word selection, one-hot by state
	assign send_csn     = (state == cmd_pkg::ECHO_CSN);
	assign send_cmd     = (state == cmd_pkg::ECHO_CC);
	assign send_rx_data = (state == cmd_pkg::ECHO_DATA);
	assign send_pad     = (state == cmd_pkg::ECHO_PAD);

	assign sm_done = (state == cmd_pkg::DONE);

	// Header and pad words are always ready to go
	// Echo words follow the receive side valid and last
	assign tx_valid = send_csn || send_cmd || send_pad || (send_rx_data && rx_valid);
	assign tx_last  = send_pad || (send_rx_data && rx_last);

	// Receive side is stalled by transmit back-pressure during the echo
	assign sm_rx_ready = send_rx_data && tx_ready;

	// Starved cycle, counted by the stall timer
	// Back-pressure on tx does not count here
	assign echo_wait = send_rx_data && !rx_valid;

endmodule

// File: hw/stall_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Echo stall timer
// Counts consecutive starved receive cycles, one timeout pulse at the limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module stall_timer #(
	parameter int unsigned TIMEOUT_CYCLES = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic echo_wait,
	output logic timeout
);

	// Wide enough to hold the limit itself, where the count saturates
	localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	logic [CNT_W-1:0] count;

	// Any cycle with data present restarts the count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count <= '0;
		else if (!echo_wait)
			count <= '0;
		else if (count != CNT_W'(TIMEOUT_CYCLES))
			count <= count + 1'b1;
	end

	// Fires on the starved cycle that brings the count to the limit
	// Saturation keeps it from firing again in the same stall
	assign timeout = echo_wait && (count == CNT_W'(TIMEOUT_CYCLES - 1));

endmodule

// File: hw/response_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response word multiplexer
// Keeps the serial number and code of the current packet and picks the
// word presented on the transmit stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module response_mux (
	input  logic           clk,
	input  logic           rst_n,
	input  cmd_pkg::word_t rx_data,
	input  logic           load_csn,
	input  logic           load_cc,
	input  logic           send_csn,
	input  logic           send_cmd,
	input  logic           send_rx_data,
	input  logic           send_pad,
	output cmd_pkg::word_t tx_data
);

	cmd_pkg::word_t csn_q;
	cmd_pkg::word_t cc_q;

	// Header words, captured on the dispatcher strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csn_q <= '0;
			cc_q  <= '0;
		end else begin
			if (load_csn)
				csn_q <= rx_data;
			if (load_cc)
				cc_q <= rx_data;
		end
	end

	// Selects are one-hot, zero when the machine is idle
	always_comb begin
		tx_data = '0;
		if (send_csn)
			tx_data = csn_q;
		else if (send_cmd)
			tx_data = cc_q;
		else if (send_rx_data)
			tx_data = rx_data;
		else if (send_pad)
			tx_data = cmd_pkg::PAD_WORD;
	end

endmodule

// File: hw/cmd_loopback_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loopback command processor top level
// Dispatcher, loopback machine, stall timer and response mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module cmd_loopback_top #(
	parameter int unsigned TIMEOUT_CYCLES = 16
) (
	input  logic           clk,
	input  logic           rst_n,
	// Command stream in
	input  logic           rx_valid,
	input  cmd_pkg::word_t rx_data,
	input  logic           rx_last,
	output logic           rx_ready,
	// Response stream out
	output logic           tx_valid,
	output cmd_pkg::word_t tx_data,
	output logic           tx_last,
	input  logic           tx_ready
);

	// Dispatcher to loopback machine
	logic run_sm;
	logic sm_done;
	logic sm_rx_ready;
	// Header capture strobes
	logic load_csn;
	logic load_cc;
	// Transmit word selects
	logic send_csn;
	logic send_cmd;
	logic send_rx_data;
	logic send_pad;
	// Stall detection
	logic echo_wait;
	logic timeout;

	cmd_dispatch u_dispatch (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.rx_last     (rx_last),
		.rx_ready    (rx_ready),
		.sm_rx_ready (sm_rx_ready),
		.sm_done     (sm_done),
		.timeout     (timeout),
		.run_sm      (run_sm),
		.load_csn    (load_csn),
		.load_cc     (load_cc)
	);

	cc_loopback_sm u_loopback (
		.clk          (clk),
		.rst_n        (rst_n),
		.run_sm       (run_sm),
		.rx_valid     (rx_valid),
		.rx_last      (rx_last),
		.sm_rx_ready  (sm_rx_ready),
		.tx_ready     (tx_ready),
		.tx_valid     (tx_valid),
		.tx_last      (tx_last),
		.timeout      (timeout),
		.echo_wait    (echo_wait),
		.sm_done      (sm_done),
		.send_csn     (send_csn),
		.send_cmd     (send_cmd),
		.send_rx_data (send_rx_data),
		.send_pad     (send_pad)
	);

	stall_timer #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_stall_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.echo_wait (echo_wait),
		.timeout   (timeout)
	);

	response_mux u_response_mux (
		.clk          (clk),
		.rst_n        (rst_n),
		.rx_data      (rx_data),
		.load_csn     (load_csn),
		.load_cc      (load_cc),
		.send_csn     (send_csn),
		.send_cmd     (send_cmd),
		.send_rx_data (send_rx_data),
		.send_pad     (send_pad),
		.tx_data      (tx_data)
	);

endmodule

// File: tests/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// 4 ns clock, power-on reset for 3 cycles, extra reset on request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_clk_gen (
	input  logic reset_req,
	output logic clk,
	output logic rst_n
);

	logic por_n;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Released on a falling edge, away from the capturing edge
	initial begin
		por_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		por_n = 1'b1;
	end

	assign rst_n = por_n && !reset_req;

endmodule

// File: tests/cmd_loopback_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream handshake and loopback machine assertions, bound into the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module cmd_loopback_sva (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 rx_valid,
	input cmd_pkg::word_t       rx_data,
	input logic                 rx_last,
	input logic                 rx_ready,
	input logic                 tx_valid,
	input cmd_pkg::word_t       tx_data,
	input logic                 tx_last,
	input logic                 tx_ready,
	input logic                 run_sm,
	input cmd_pkg::loop_state_t loop_state
);

	// Waiting receive word holds until taken
	rx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_data) && $stable(rx_last))
		else $error("receive word dropped or changed before its transfer");

	// Same rule on the response side
	tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
		else $error("response word dropped or changed before its transfer");

	// Loopback machine parked while the dispatcher is not running it
	idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!run_sm |-> loop_state == cmd_pkg::IDLE)
		else $error("loopback machine left IDLE without run_sm");

endmodule

bind cmd_loopback_top cmd_loopback_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.rx_valid   (rx_valid),
	.rx_data    (rx_data),
	.rx_last    (rx_last),
	.rx_ready   (rx_ready),
	.tx_valid   (tx_valid),
	.tx_data    (tx_data),
	.tx_last    (tx_last),
	.tx_ready   (tx_ready),
	.run_sm     (run_sm),
	.loop_state (u_loopback.state)
);

// File: tests/tb_cmd_loopback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loopback command processor testbench
// Streams command packets in and checks every response word against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_cmd_loopback;

	localparam int unsigned TIMEOUT_CYCLES = 16;
	// Cycle budget of any single wait
	localparam int WAIT_LIMIT = 4000;

	logic           clk;
	logic           rst_n;
	logic           reset_req;
	logic           rx_valid;
	cmd_pkg::word_t rx_data;
	logic           rx_last;
	logic           rx_ready;
	logic           tx_valid;
	cmd_pkg::word_t tx_data;
	logic           tx_last;
	logic           tx_ready;

	// Sink behavior, 0 random, 1 with long stalls, 2 held low
	int sink_mode;
	int stall_left;
	int checked = 0;
	// Packet being sent and the response words still owed
	cmd_pkg::word_t pkt[$];
	cmd_pkg::word_t exp_data[$];
	logic exp_last[$];

	tb_clk_gen u_clk_gen (.*);

	cmd_loopback_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_dut (.*);

	task automatic fail_run();
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// Expected response of one packet
	// stall_at is the index of the word held back past the timeout, or -1
	function automatic void model_response(input cmd_pkg::word_t p[$], input int stall_at);
		int n;
		// Unknown codes are drained silently
		if (p[1] != cmd_pkg::CC_LOOPBACK)
			return;
		n = (stall_at < 0) ? p.size() : stall_at;
		for (int i = 0; i < n; i++) begin
			exp_data.push_back(p[i]);
			exp_last.push_back(stall_at < 0 && i == n - 1);
		end
		// Cut short, closed by the pad word
		if (stall_at >= 0) begin
			exp_data.push_back(cmd_pkg::PAD_WORD);
			exp_last.push_back(1'b1);
		end
	endfunction

	// Serial number, code, count, then n_data data words
	function automatic void build_packet(input cmd_pkg::word_t cc, input int n_data);
		pkt.delete();
		pkt.push_back($urandom());
		pkt.push_back(cc);
		pkt.push_back(cmd_pkg::word_t'(n_data));
		repeat (n_data) pkt.push_back($urandom());
	endfunction

	// Power-on reset, until rst_n is released
	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timeout at %0t: reset never released", $time);
				fail_run();
			end
		end
	endtask

	// One receive word after gap idle cycles, held until taken
	task automatic drive_word(input cmd_pkg::word_t d, input logic last, input int gap);
		int waited;
		waited = 0;
		if (gap > 0) begin
			rx_valid = 1'b0;
			repeat (gap) @(negedge clk);
		end
		rx_valid = 1'b1;
		rx_data  = d;
		rx_last  = last;
		do begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timeout at %0t: receive word never accepted", $time);
				fail_run();
			end
		end while (!rx_ready);
		@(negedge clk);
	endtask

	// Short random gaps, or one long stall in front of word stall_at
	task automatic send_packet(input int max_gap, input int stall_at);
		int gap;
		model_response(pkt, stall_at);
		foreach (pkt[i]) begin
			gap = (max_gap > 0) ? $urandom_range(max_gap) : 0;
			if (i == stall_at)
				gap = TIMEOUT_CYCLES + 8;
			drive_word(pkt[i], i == pkt.size() - 1, gap);
		end
		rx_valid = 1'b0;
		rx_last  = 1'b0;
	endtask

	// Until every owed word is out, then a quiet stretch for stray words
	task automatic wait_responses();
		int waited;
		waited = 0;
		while (exp_data.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timeout at %0t: %0d response words missing", $time, exp_data.size());
				fail_run();
			end
		end
		repeat (20) @(negedge clk);
	endtask

	// Reset while the echo is stuck on a blocked transmit side
	task automatic reset_mid_packet();
		build_packet(cmd_pkg::CC_LOOPBACK, 6);
		sink_mode = 2;
		repeat (2) @(negedge clk);
		drive_word(pkt[0], 1'b0, 0);
		drive_word(pkt[1], 1'b0, 0);
		rx_data = pkt[2];
		repeat (4) @(negedge clk);
		assert (tx_valid && !rx_ready) else begin
			$display("CHECK FAILED at %0t: echo not pending before reset", $time);
			fail_run();
		end
		rx_valid  = 1'b0;
		reset_req = 1'b1;
		repeat (3) @(negedge clk);
		// Dispatcher sits in GET_CSN, so it is ready for a header
		assert (!tx_valid && !tx_last && rx_ready) else begin
			$display("CHECK FAILED at %0t: outputs not at reset values", $time);
			fail_run();
		end
		reset_req = 1'b0;
		sink_mode = 0;
	endtask

	// Response sink with random back-pressure
	always @(negedge clk) begin
		if (sink_mode == 2) begin
			tx_ready = 1'b0;
		end else if (stall_left > 0) begin
			tx_ready = 1'b0;
			stall_left--;
		end else if (sink_mode == 1 && $urandom_range(9) == 0) begin
			tx_ready = 1'b0;
			stall_left = $urandom_range(40, 20);
		end else begin
			tx_ready = ($urandom_range(3) != 0);
		end
	end

	// Compare each transmit transfer with the next owed word
	always @(posedge clk) begin : compare
		cmd_pkg::word_t want;
		logic want_last;
		if (rst_n && tx_valid && tx_ready) begin
			assert (exp_data.size() != 0) else begin
				$display("CHECK FAILED at %0t: unexpected response word %h", $time, tx_data);
				fail_run();
			end
			want      = exp_data.pop_front();
			want_last = exp_last.pop_front();
			checked++;
			assert (tx_data == want) else begin
				$display("CHECK FAILED at %0t: tx_data %h, expected %h", $time, tx_data, want);
				fail_run();
			end
			assert (tx_last == want_last) else begin
				$display("CHECK FAILED at %0t: tx_last %b, expected %b", $time, tx_last,
					want_last);
				fail_run();
			end
		end
	end

	initial begin
		void'($urandom(32'he293));
		reset_req  = 1'b0;
		rx_valid   = 1'b0;
		rx_data    = '0;
		rx_last    = 1'b0;
		tx_ready   = 1'b0;
		sink_mode  = 0;
		stall_left = 0;
		wait_reset_release();
		@(negedge clk);
		// Minimum packet, count word carries last
		build_packet(cmd_pkg::CC_LOOPBACK, 0);
		send_packet(0, -1);
		wait_responses();
		// Random lengths, gaps well under the stall limit
		repeat (30) begin
			build_packet(cmd_pkg::CC_LOOPBACK, $urandom_range(17));
			send_packet(8, -1);
		end
		wait_responses();
		// Unknown code drained, next packet still echoed
		build_packet(cmd_pkg::CC_LOOPBACK + 32'd7, 6);
		send_packet(3, -1);
		build_packet(cmd_pkg::CC_LOOPBACK, 4);
		send_packet(3, -1);
		wait_responses();
		// Receive stall past the limit, tail of the packet dropped
		build_packet(cmd_pkg::CC_LOOPBACK, 8);
		send_packet(2, 5);
		build_packet(cmd_pkg::CC_LOOPBACK, 5);
		send_packet(2, -1);
		wait_responses();
		// Back to back under long transmit stalls
		sink_mode = 1;
		repeat (8) begin
			build_packet(cmd_pkg::CC_LOOPBACK, $urandom_range(17));
			send_packet(0, -1);
		end
		wait_responses();
		sink_mode = 0;
		reset_mid_packet();
		build_packet(cmd_pkg::CC_LOOPBACK, 6);
		send_packet(4, -1);
		wait_responses();
		if (checked > 0 && exp_data.size() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("No response words were checked");
			fail_run();
		end
	end

endmodule

// File: cmd_loopback.f
hw/cmd_pkg.sv
hw/cmd_dispatch.sv
hw/cc_loopback_sm.sv
hw/stall_timer.sv
hw/response_mux.sv
hw/cmd_loopback_top.sv
tests/tb_clk_gen.sv
tests/cmd_loopback_sva.sv
tests/tb_cmd_loopback.sv

// File: Bender.yml
package:
  name: cmd_loopback

sources:
  - hw/cmd_pkg.sv
  - hw/cmd_dispatch.sv
  - hw/cc_loopback_sm.sv
  - hw/stall_timer.sv
  - hw/response_mux.sv
  - hw/cmd_loopback_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/cmd_loopback_sva.sv
      - tests/tb_cmd_loopback.sv
